// File: bench/alu_assertions.sv
// Protocol checks on the ALU top level
// Reset state, request and response exclusion, held response
// stability and zero flag consistency, bound into alu_top
`timescale 1ns/10ps

module alu_assertions import alu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  op_ready,
    input logic  res_valid,
    input logic  res_ready,
    input word_t result,
    input logic  zero_flag,
    input logic  sign_flag,
    input logic  carry_flag,
    input logic  overflow_flag,
    input logic  error_flag
);

    int         fail_cnt = 0;             // Read by the testbench report
    word_t      prev_result;
    logic [4:0] prev_flags;
    logic [4:0] flags;

    assign flags = {zero_flag, sign_flag, carry_flag, overflow_flag, error_flag};

    always_ff @(posedge clk) begin
        prev_result <= result;              // Value one edge back
        prev_flags  <= flags;
    end

    // Idle and empty on the first edge out of reset
    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> op_ready && !res_valid)
        else begin
            $error("ERR %0t res_valid after reset expected 0 got %b", $time, res_valid);
            fail_cnt++;
        end

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
                                    !(op_ready && res_valid))
        else begin
            $error("ERR %0t op_ready and res_valid are high together", $time);
            fail_cnt++;
        end

    // Back-pressure freezes the response
    held_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                  res_valid && !res_ready |=>
                                  result == prev_result && flags == prev_flags)
        else begin
            $error("ERR %0t result held %h now %h, flags held %b now %b",
                   $time, prev_result, result, prev_flags, flags);
            fail_cnt++;
        end

    zero_match: assert property (@(posedge clk) disable iff (!rst_n)
                                 zero_flag == (result == '0))
        else begin
            $error("ERR %0t zero_flag expected %b got %b", $time, result == '0, zero_flag);
            fail_cnt++;
        end

endmodule

bind alu_top alu_assertions u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_ready     (op_ready),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .result       (result),
    .zero_flag    (zero_flag),
    .sign_flag    (sign_flag),
    .carry_flag   (carry_flag),
    .overflow_flag(overflow_flag),
    .error_flag   (error_flag)
);

// File: bench/alu_tb.sv
// Testbench for the sequenced RISC-V ALU
// Random and corner operands over every operation class, a reference
// model predicting each response, random response back-pressure and
// a watchdog
`timescale 1ns/10ps

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int MAX_OPS       = 400;   // Upper bound on issued operations
    localparam int CYCLES_PER_OP = 40;    // Divide plus a few stall cycles

    logic    clk;
    logic    rst_n;
    logic    op_valid;
    logic    op_ready;
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   immediate;
    logic    use_immediate;
    logic    res_valid;
    logic    res_ready;
    word_t   result;
    logic    zero_flag;
    logic    sign_flag;
    logic    carry_flag;
    logic    overflow_flag;
    logic    error_flag;

    integer  seed = 78011;
    int      errors = 0;
    dword_t  mac_model = '0;              // Reference accumulator
    word_t   exp_res;
    logic    exp_zero, exp_sign, exp_carry, exp_ovf, exp_err;
    logic    exp_slow;                    // Goes through the serial divider

    alu_top #(.XLEN(XLEN)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(MAX_OPS * CYCLES_PER_OP * CLK_PERIOD);
        $display("Timeout: the operations did not complete in the expected time");
        $display("Simulation failed");
        $finish;
    end

    // Mostly random, sometimes a corner word
    function automatic word_t pick_operand();
        int sel;
        sel = $random(seed) & 7;
        case (sel)
            0:       return '0;
            1:       return '1;                       // Minus one
            2:       return 32'h8000_0000;            // Most negative
            3:       return word_t'($random(seed) & 31);
            default: return word_t'($random(seed));
        endcase
    endfunction

    function automatic logic draw_ready();
        return ($random(seed) & 3) != 0;              // Ready three times in four
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Reference model, evaluated at acceptance
    task automatic predict_response(input opcode_t opc, input funct3_t f3, input funct7_t f7,
                                    input word_t a, input word_t b);
        longint sa, sb, wide;
        sa        = longint'($signed(a));
        sb        = longint'($signed(b));
        exp_res   = '0;
        exp_carry = 1'b0;
        exp_ovf   = 1'b0;
        exp_err   = 1'b0;
        exp_slow  = 1'b0;
        if (opc == OP_REG && f7 == F7_MULDIV && !f3[2]) begin
            case (f3[1:0])
                2'b00:   exp_res = word_t'(sa * sb);
                2'b01:   exp_res = word_t'((sa * sb) >>> 32);
                2'b10:   exp_res = word_t'((sa * longint'(b)) >>> 32);   // Signed by unsigned
                default: exp_res = word_t'((dword_t'(a) * dword_t'(b)) >> 32);
            endcase
        end else if (opc == OP_REG && f7 == F7_MULDIV) begin
            if (b == '0) begin
                exp_res = f3[1] ? a : '1;
                exp_err = 1'b1;
            end else begin
                exp_slow = 1'b1;
                case (f3[1:0])                          // 64-bit math covers min / -1
                    2'b00:   exp_res = word_t'(sa / sb);
                    2'b01:   exp_res = a / b;
                    2'b10:   exp_res = word_t'(sa % sb);
                    default: exp_res = a % b;
                endcase
            end
        end else if (opc == OP_REG || opc == OP_IMM) begin
            case (f3)
                3'b000: begin
                    if (opc == OP_REG && f7[5]) begin
                        wide      = sa - sb;
                        exp_res   = a - b;
                        exp_carry = a < b;              // Borrow out
                    end else begin
                        wide      = sa + sb;
                        exp_res   = a + b;
                        exp_carry = (dword_t'(a) + dword_t'(b)) > 64'hFFFF_FFFF;
                    end
                    exp_ovf = (wide != longint'($signed(exp_res)));
                end
                3'b001:  exp_res = a << b[4:0];
                3'b010:  exp_res = word_t'(sa < sb);
                3'b011:  exp_res = word_t'(a < b);
                3'b100:  exp_res = a ^ b;
                3'b101:  exp_res = f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  exp_res = a | b;
                default: exp_res = a & b;
            endcase
        end else if (opc == OP_CUST_MAT && f3 == 3'b001) begin
            mac_model = mac_model + dword_t'(a) * dword_t'(b);
            exp_res   = mac_model[31:0];
        end else if (opc == OP_CUST_POOL && f3[2:1] == 2'b00) begin
            exp_res = f3[0] ? word_t'((dword_t'(a) + dword_t'(b)) >> 1) : ((a > b) ? a : b);
        end else begin
            exp_err = 1'b1;                             // Matrix, unknown opcodes
        end
        exp_zero = (exp_res == '0);
        exp_sign = exp_res[31];
    endtask

    // One request, then wait for the response under random back-pressure
    task automatic issue_op(input opcode_t opc, input funct3_t f3, input funct7_t f7,
                            input word_t a, input word_t b, input logic use_imm);
        int lat;
        int want_lat;
        opcode        <= opc;
        funct3        <= f3;
        funct7        <= f7;
        rs1_data      <= a;
        rs2_data      <= use_imm ? word_t'($random(seed)) : b;   // Unused side is noise
        immediate     <= use_imm ? b : word_t'($random(seed));
        use_immediate <= use_imm;
        op_valid      <= 1'b1;
        @(posedge clk);
        while (!op_ready) @(posedge clk);
        op_valid <= 1'b0;                               // Accepted on this edge
        predict_response(opc, f3, f7, a, b);
        lat = 0;
        res_ready <= draw_ready();
        @(posedge clk);
        while (!res_valid) begin
            lat++;
            res_ready <= draw_ready();
            @(posedge clk);
        end
        want_lat = exp_slow ? XLEN + 1 : 1;
        assert (lat == want_lat)
        else begin
            $display("ERR %0t res_valid latency expected %0d got %0d", $time, want_lat, lat);
            errors++;
        end
        while (!res_ready) begin                        // Held response
            res_ready <= draw_ready();
            @(posedge clk);
        end
        compare_word("result", exp_res, result);
        compare_word("zero_flag", word_t'(exp_zero), word_t'(zero_flag));
        compare_word("sign_flag", word_t'(exp_sign), word_t'(sign_flag));
        compare_word("carry_flag", word_t'(exp_carry), word_t'(carry_flag));
        compare_word("overflow_flag", word_t'(exp_ovf), word_t'(overflow_flag));
        compare_word("error_flag", word_t'(exp_err), word_t'(error_flag));
    endtask

    initial begin
        int      i;
        funct7_t f7;
        word_t   a, b;
        rst_n         <= 1'b0;
        op_valid      <= 1'b0;
        opcode        <= '0;
        funct3        <= '0;
        funct7        <= '0;
        rs1_data      <= '0;
        rs2_data      <= '0;
        immediate     <= '0;
        use_immediate <= 1'b0;
        res_ready     <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // RV32I, register and immediate forms, both funct7 values
        for (i = 0; i < 64; i++) begin
            f7 = i[4] ? 7'b0100000 : 7'b0000000;
            a  = pick_operand();
            b  = pick_operand();
            issue_op(i[0] ? OP_IMM : OP_REG, funct3_t'(i[3:1]), f7, a, b, i[0]);
        end
        for (i = 0; i < 40; i++) begin                  // MUL, MULH, MULHSU, MULHU
            a = pick_operand();
            b = pick_operand();
            issue_op(OP_REG, funct3_t'(i[1:0]), F7_MULDIV, a, b, 1'b0);
        end
        for (i = 0; i < 48; i++) begin                  // DIV, DIVU, REM, REMU
            a = pick_operand();
            b = pick_operand();
            issue_op(OP_REG, funct3_t'({1'b1, i[1:0]}), F7_MULDIV, a, b, 1'b0);
        end
        for (i = 0; i < 4; i++)                         // Zero divisor
            issue_op(OP_REG, funct3_t'(4 + i), F7_MULDIV, pick_operand(), '0, 1'b0);
        issue_op(OP_REG, 3'b100, F7_MULDIV, 32'h8000_0000, '1, 1'b0);   // Signed overflow
        issue_op(OP_REG, 3'b110, F7_MULDIV, 32'h8000_0000, '1, 1'b0);

        // MAC with other classes in between
        for (i = 0; i < 16; i++) begin
            issue_op(OP_CUST_MAT, 3'b001, '0, pick_operand(), pick_operand(), 1'b0);
            if (i[0])
                issue_op(OP_CUST_POOL, funct3_t'(i[1]), '0, pick_operand(), pick_operand(), 1'b0);
            else
                issue_op(OP_REG, 3'b000, F7_MULDIV, pick_operand(), pick_operand(), 1'b0);
        end
        for (i = 0; i < 16; i++)                        // Max and average
            issue_op(OP_CUST_POOL, funct3_t'(i[0]), '0, pick_operand(), pick_operand(), 1'b0);

        // Dropped and unknown encodings
        issue_op(OP_CUST_MAT, 3'b000, '0, pick_operand(), pick_operand(), 1'b0);  // Old matmul
        issue_op(OP_CUST_MAT, 3'b111, '0, pick_operand(), pick_operand(), 1'b0);
        issue_op(OP_CUST_POOL, 3'b010, '0, pick_operand(), pick_operand(), 1'b0);
        issue_op(OP_CUST_POOL, 3'b100, '0, pick_operand(), pick_operand(), 1'b0);
        issue_op(7'b1111111, 3'b000, '0, pick_operand(), pick_operand(), 1'b0);
        issue_op(7'b0000011, 3'b010, '0, pick_operand(), pick_operand(), 1'b0);  // Load

        repeat (2) @(posedge clk);
        $display("Errors: checks %0d, protocol %0d", errors, dut.u_assert.fail_cnt);
        if (errors == 0 && dut.u_assert.fail_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: rtl/alu_ctrl_fsm.sv
// ALU controller
// Accepts one request at a time, decodes it into an operation class,
// steers the execution units and holds the response with its flags
// until the consumer takes it
`timescale 1ns/10ps

module alu_ctrl_fsm import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            op_valid,
    output logic            op_ready,
    input  opcode_t         opcode,
    input  funct3_t         funct3,
    input  funct7_t         funct7,
    input  word_t           rs1_data,
    input  word_t           rs2_data,
    input  word_t           immediate,
    input  logic            use_immediate,
    output logic            res_valid,
    input  logic            res_ready,
    output word_t           result,
    output logic            zero_flag,
    output logic            sign_flag,
    output logic            carry_flag,
    output logic            overflow_flag,
    output logic            error_flag,
    output logic            div_start,
    output logic            mac_en,
    output logic            pool_en,
    input  logic [XLEN-1:0] int_result,
    input  logic            int_carry,
    input  logic            int_overflow,
    input  logic [XLEN-1:0] mul_result,
    input  logic [XLEN-1:0] div_result,
    input  logic            div_done,
    input  logic [XLEN-1:0] media_result,
    alu_op_if.ctrl          op
);

    ctrl_state_e state;
    op_class_e   cls_d, cls_q;
    logic        addsub_q;      // Only add and sub report carry and overflow
    logic        accept;
    logic        div_zero;
    logic        load_res;
    word_t       nxt_result;
    logic        nxt_error;

    assign op_ready  = (state == S_IDLE);
    assign res_valid = (state == S_HOLD);
    assign accept    = op_valid && op_ready;
    assign div_zero  = (op.operand_b == '0);

    // Unit strobes, all confined to the execute cycle
    assign div_start = (state == S_EXEC) && (cls_q == CLS_DIV) && !div_zero;
    assign mac_en    = (state == S_EXEC) && (cls_q == CLS_MAC);
    assign pool_en   = (state == S_EXEC) && (cls_q == CLS_POOL);
    assign load_res  = ((state == S_EXEC) && !div_start) || ((state == S_DIV) && div_done);

    // Opcode decode
    always_comb begin
        case (opcode)
            OP_REG: begin
                if (funct7 == F7_MULDIV)
                    cls_d = funct3[2] ? CLS_DIV : CLS_MUL;   // 1xx divide, 0xx multiply
                else
                    cls_d = CLS_INT;
            end
            OP_IMM:       cls_d = CLS_INT;
            OP_CUST_MAT:  cls_d = (funct3 == 3'b001) ? CLS_MAC : CLS_ILLEGAL;  // 000 was matmul
            OP_CUST_POOL: cls_d = (funct3[2:1] == 2'b00) ? CLS_POOL : CLS_ILLEGAL;
            default:      cls_d = CLS_ILLEGAL;
        endcase
    end

    // Result select
    always_comb begin
        nxt_error = 1'b0;
        if (state == S_DIV) begin
            nxt_result = div_result;
        end else begin
            case (cls_q)
                CLS_INT:  nxt_result = int_result;
                CLS_MUL:  nxt_result = mul_result;
                CLS_DIV: begin                       // Only reached with a zero divisor
                    nxt_result = op.funct3[1] ? op.operand_a : '1;
                    nxt_error  = 1'b1;
                end
                CLS_MAC,
                CLS_POOL: nxt_result = media_result;
                default: begin
                    nxt_result = '0;
                    nxt_error  = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            cls_q    <= CLS_ILLEGAL;
            addsub_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state    <= S_EXEC;
                        cls_q    <= cls_d;
                        addsub_q <= (cls_d == CLS_INT) && (funct3 == 3'b000);
                    end
                end
                S_EXEC:  state <= div_start ? S_DIV : S_HOLD;
                S_DIV:   if (div_done) state <= S_HOLD;
                default: if (res_ready) state <= S_IDLE;   // S_HOLD
            endcase
        end
    end

    // Operand latch, stable for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            op.operand_a <= rs1_data;
            op.operand_b <= use_immediate ? immediate : rs2_data;
            op.funct3    <= funct3;
            op.alt       <= funct7[5] && !(opcode == OP_IMM && funct3 == 3'b000);  // No SUBI
        end
    end

    // Response register, frozen while held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result        <= '0;
            zero_flag     <= 1'b1;       // Matches the cleared result
            sign_flag     <= 1'b0;
            carry_flag    <= 1'b0;
            overflow_flag <= 1'b0;
            error_flag    <= 1'b0;
        end else if (load_res) begin
            result        <= nxt_result;
            zero_flag     <= (nxt_result == '0);
            sign_flag     <= nxt_result[XLEN-1];
            carry_flag    <= addsub_q && (state == S_EXEC) && int_carry;
            overflow_flag <= addsub_q && (state == S_EXEC) && int_overflow;
            error_flag    <= nxt_error;
        end
    end

endmodule

// File: rtl/alu_op_if.sv
// Latched operation bus
// Controller drives the operands and function bits of the current
// operation, every execution unit reads them
`timescale 1ns/10ps

interface alu_op_if import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
);

    logic [XLEN-1:0] operand_a;   // rs1
    logic [XLEN-1:0] operand_b;   // rs2 or immediate
    funct3_t         funct3;
    logic            alt;         // funct7 bit 5, SUB and SRA select

    modport ctrl (
        output operand_a,
        output operand_b,
        output funct3,
        output alt
    );

    modport unit (
        input operand_a,
        input operand_b,
        input funct3,
        input alt
    );

endinterface

// File: rtl/alu_pkg.sv
// ALU shared definitions
// Data widths, RISC-V opcodes and function codes, operation classes
// and the controller state encoding
package alu_pkg;

    localparam int XLEN = 32;              // Data word width

    typedef logic [31:0] word_t;           // Operand, result, immediate
    typedef logic [63:0] dword_t;          // Full product, MAC accumulator
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Opcodes accepted by the unit
    localparam opcode_t OP_REG       = 7'b0110011;  // R-type, RV32I and RV32M
    localparam opcode_t OP_IMM       = 7'b0010011;  // I-type integer
    localparam opcode_t OP_CUST_MAT  = 7'b0001011;  // Custom-0, MAC (matrix dropped)
    localparam opcode_t OP_CUST_POOL = 7'b0001111;  // Max and average pooling

    localparam funct7_t F7_MULDIV = 7'b0000001;     // RV32M marker

    // Which unit produces the result
    typedef enum logic [2:0] {
        CLS_INT,
        CLS_MUL,
        CLS_DIV,
        CLS_MAC,
        CLS_POOL,
        CLS_ILLEGAL
    } op_class_e;

    typedef enum logic [1:0] {
        S_IDLE,    // Waiting for a request
        S_EXEC,    // Operands latched, units evaluate
        S_DIV,     // Serial divide running
        S_HOLD     // Response valid until taken
    } ctrl_state_e;

endpackage

// File: rtl/alu_top.sv
// RISC-V execution unit top level
// Sequenced RV32I and RV32M ALU with MAC and pooling extensions,
// valid/ready request and response on plain ports
`timescale 1ns/10ps

module alu_top import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    op_valid,
    output logic    op_ready,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   immediate,
    input  logic    use_immediate,
    output logic    res_valid,
    input  logic    res_ready,
    output word_t   result,
    output logic    zero_flag,
    output logic    sign_flag,
    output logic    carry_flag,
    output logic    overflow_flag,
    output logic    error_flag
);

    logic [XLEN-1:0] int_result, mul_result, div_result, media_result;
    logic            int_carry, int_overflow;
    logic            div_start, div_done;
    logic            mac_en, pool_en;

    alu_op_if #(.XLEN(XLEN)) op_bus ();   // Latched operation

    alu_ctrl_fsm #(.XLEN(XLEN)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .immediate    (immediate),
        .use_immediate(use_immediate),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .result       (result),
        .zero_flag    (zero_flag),
        .sign_flag    (sign_flag),
        .carry_flag   (carry_flag),
        .overflow_flag(overflow_flag),
        .error_flag   (error_flag),
        .div_start    (div_start),
        .mac_en       (mac_en),
        .pool_en      (pool_en),
        .int_result   (int_result),
        .int_carry    (int_carry),
        .int_overflow (int_overflow),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .div_done     (div_done),
        .media_result (media_result),
        .op           (op_bus.ctrl)
    );

    int_alu #(.XLEN(XLEN)) u_int (
        .op          (op_bus.unit),
        .int_result  (int_result),
        .int_carry   (int_carry),
        .int_overflow(int_overflow)
    );

    mul_unit #(.XLEN(XLEN)) u_mul (
        .op        (op_bus.unit),
        .mul_result(mul_result)
    );

    serial_divider #(.XLEN(XLEN)) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .op        (op_bus.unit),
        .div_done  (div_done),
        .div_result(div_result)
    );

    media_unit #(.XLEN(XLEN)) u_media (
        .clk         (clk),
        .rst_n       (rst_n),
        .mac_en      (mac_en),
        .pool_en     (pool_en),
        .op          (op_bus.unit),
        .media_result(media_result)
    );

endmodule

// File: rtl/int_alu.sv
// RV32I integer unit
// Combinational add, sub, shifts, compares and logic ops selected by
// funct3, with carry and two's complement overflow for add and sub
`timescale 1ns/10ps

module int_alu import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    alu_op_if.unit          op,
    output logic [XLEN-1:0] int_result,
    output logic            int_carry,
    output logic            int_overflow
);

    localparam int SW = $clog2(XLEN);   // Shift amount width

    logic [XLEN:0]   sum_ext;            // Carry in the top bit
    logic [XLEN:0]   dif_ext;            // Borrow in the top bit
    logic [SW-1:0]   shamt;
    logic            sa, sb;

    assign sa      = op.operand_a[XLEN-1];
    assign sb      = op.operand_b[XLEN-1];
    assign shamt   = op.operand_b[SW-1:0];
    assign sum_ext = {1'b0, op.operand_a} + {1'b0, op.operand_b};
    assign dif_ext = {1'b0, op.operand_a} - {1'b0, op.operand_b};

    assign int_carry    = op.alt ? dif_ext[XLEN] : sum_ext[XLEN];
    assign int_overflow = op.alt ? ((sa != sb) && (dif_ext[XLEN-1] != sa))   // Sub
                                 : ((sa == sb) && (sum_ext[XLEN-1] != sa));  // Add

    always_comb begin
        case (op.funct3)
            3'b000:  int_result = op.alt ? dif_ext[XLEN-1:0] : sum_ext[XLEN-1:0];
            3'b001:  int_result = op.operand_a << shamt;                     // SLL
            3'b010:  int_result = XLEN'($signed(op.operand_a) < $signed(op.operand_b));
            3'b011:  int_result = XLEN'(op.operand_a < op.operand_b);        // SLTU
            3'b100:  int_result = op.operand_a ^ op.operand_b;
            3'b101: begin
                if (op.alt)
                    int_result = $signed(op.operand_a) >>> shamt;            // SRA
                else
                    int_result = op.operand_a >> shamt;
            end
            3'b110:  int_result = op.operand_a | op.operand_b;
            default: int_result = op.operand_a & op.operand_b;               // AND
        endcase
    end

endmodule

// File: rtl/media_unit.sv
// Media unit
// Unsigned multiply-accumulate into a 64-bit accumulator, and
// max or floor-average pooling of two words
`timescale 1ns/10ps

module media_unit import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mac_en,
    input  logic            pool_en,
    alu_op_if.unit          op,
    output logic [XLEN-1:0] media_result
);

    dword_t            mac_acc;        // Cleared by reset only
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   mac_word;
    logic [XLEN:0]     pool_sum;
    logic [XLEN-1:0]   pool_word;

    assign product  = op.operand_a * op.operand_b;          // Unsigned
    assign mac_word = mac_acc[XLEN-1:0] + product[XLEN-1:0];

    assign pool_sum  = {1'b0, op.operand_a} + {1'b0, op.operand_b};
    assign pool_word = op.funct3[0] ? pool_sum[XLEN:1]      // Floor average
                                    : ((op.operand_a > op.operand_b) ? op.operand_a
                                                                     : op.operand_b);

    assign media_result = pool_en ? pool_word : mac_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mac_acc <= '0;
        else if (mac_en)
            mac_acc <= mac_acc + product;
    end

endmodule

// File: rtl/mul_unit.sv
// RV32M multiplier
// One double-width product with per-operand signedness, low word for MUL,
// high word for MULH, MULHSU and MULHU
`timescale 1ns/10ps

module mul_unit import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    alu_op_if.unit          op,
    output logic [XLEN-1:0] mul_result
);

    logic              a_signed, b_signed;
    logic [2*XLEN-1:0] a_ext, b_ext;
    logic [2*XLEN-1:0] product;

    assign a_signed = (op.funct3[1:0] != 2'b11);   // MULHU treats both unsigned
    assign b_signed = !op.funct3[1];               // Only MUL and MULH sign rs2

    // Sign extended to full width, truncated product is exact
    assign a_ext   = {{XLEN{a_signed && op.operand_a[XLEN-1]}}, op.operand_a};
    assign b_ext   = {{XLEN{b_signed && op.operand_b[XLEN-1]}}, op.operand_b};
    assign product = a_ext * b_ext;

    assign mul_result = (op.funct3[1:0] == 2'b00) ? product[XLEN-1:0]
                                                  : product[2*XLEN-1:XLEN];

endmodule

// File: rtl/serial_divider.sv
// Serial restoring divider
// One shift-subtract step per cycle on operand magnitudes, XLEN steps,
// then sign fix of quotient and remainder for DIV, DIVU, REM and REMU
`timescale 1ns/10ps

module serial_divider import alu_pkg::*; #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            div_start,
    alu_op_if.unit          op,
    output logic            div_done,
    output logic [XLEN-1:0] div_result
);

    localparam int CW = $clog2(XLEN);

    logic [CW-1:0]   step_cnt;         // Steps still to run
    logic [XLEN-1:0] rem_q, quo_q;
    logic [XLEN-1:0] mag_a, mag_b;
    logic            neg_a, neg_b;
    logic [XLEN-1:0] rem_in, quo_in;
    logic [XLEN:0]   shifted, trial;
    logic [XLEN-1:0] rem_nx, quo_nx;

    // Operands stay latched on the bus for the whole divide
    assign neg_a = !op.funct3[0] && op.operand_a[XLEN-1];
    assign neg_b = !op.funct3[0] && op.operand_b[XLEN-1];
    assign mag_a = neg_a ? -op.operand_a : op.operand_a;
    assign mag_b = neg_b ? -op.operand_b : op.operand_b;

    // First step runs on the start edge
    assign rem_in  = div_start ? '0 : rem_q;
    assign quo_in  = div_start ? mag_a : quo_q;
    assign shifted = {rem_in, quo_in[XLEN-1]};
    assign trial   = shifted - {1'b0, mag_b};
    assign rem_nx  = trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];  // Restore on borrow
    assign quo_nx  = {quo_in[XLEN-2:0], !trial[XLEN]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
            div_done <= 1'b0;
        end else if (div_start) begin
            step_cnt <= CW'(XLEN - 1);
            div_done <= 1'b0;
        end else begin
            div_done <= (step_cnt == CW'(1));       // Last step this edge
            if (step_cnt != '0)
                step_cnt <= step_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start || step_cnt != '0) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
        end
    end

    // Min / -1 wraps to the most negative word by itself
    always_comb begin
        if (op.funct3[1])
            div_result = neg_a ? -rem_q : rem_q;            // Remainder follows dividend
        else
            div_result = (neg_a != neg_b) ? -quo_q : quo_q;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module alu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Valu_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: sources.f
rtl/alu_pkg.sv
rtl/alu_op_if.sv
rtl/int_alu.sv
rtl/mul_unit.sv
rtl/serial_divider.sv
rtl/media_unit.sv
rtl/alu_ctrl_fsm.sv
rtl/alu_top.sv
bench/alu_assertions.sv
bench/alu_tb.sv
